/* launcher_top.f */
logic/launcher_pkg.sv
logic/adc_receiver.sv
logic/fire_debounce.sv
logic/fire_sequencer.sv
logic/pwm_current_regulator.sv
logic/charge_arm_control.sv
logic/launcher_top.sv
dv/adc_serial_model.sv
dv/launcher_tb.sv

/* run_sim.sh */
#!/bin/bash
# Build and run the launcher testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
	-f launcher_top.f --top-module launcher_tb -o launcher_sim

./obj_dir/launcher_sim > sim.log 2>&1 || true
cat sim.log

grep -q "ALL CHECKS PASSED" sim.log

/* dv/launcher_tb.sv */
`default_nettype none

module launcher_tb;

	localparam int CPMS      = 16;  // Shortened millisecond
	localparam int BURN_CYC  = launcher_pkg::BURN_END_MS * CPMS;
	localparam int BLINK_CYC = launcher_pkg::BLINK_PERIOD_MS * CPMS;
	localparam int BLINK_ON  = launcher_pkg::BLINK_ON_MS * CPMS;
	localparam int TIMEOUT_CYCLES = BURN_CYC + 18000;
	localparam int MARGIN    = 150;  // ADC latency overshoot allowance

	logic clk, reset, fire_button, lt3420_done;
	logic [1:0] ad_sdata;
	logic o_ad_cs, o_ad_strobe, o_firing, o_pwm, o_dump, o_lt3420_charge, o_arm_led;
	launcher_pkg::adc_word_t o_i_out, o_v_cap;
	logic [11:0] i_word, v_word, frame_i, frame_v;

	int errors, strobes, pulses, fire_starts;
	int cs_age, strobe_gap, btn_age, fire_age, blink_age, hi_len, lo_len, plant_mag;
	logic exp_charge, firing_q, long_press, boost_reached;

	launcher_top #(.CYCLES_PER_MS(CPMS)) i_launcher_top (
		.clk (clk), .reset (reset), .i_fire_button (fire_button),
		.i_lt3420_done (lt3420_done), .i_ad_sdata_a (ad_sdata),
		.o_ad_cs (o_ad_cs), .o_ad_strobe (o_ad_strobe), .o_i_out (o_i_out),
		.o_v_cap (o_v_cap), .o_firing (o_firing), .o_pwm (o_pwm), .o_dump (o_dump),
		.o_lt3420_charge (o_lt3420_charge), .o_arm_led (o_arm_led)
	);

	adc_serial_model i_adc_serial_model (
		.clk (clk), .reset (reset), .i_cs (o_ad_cs), .i_word_i (i_word),
		.i_word_v (v_word), .o_sdata (ad_sdata), .o_frame_i (frame_i), .o_frame_v (frame_v)
	);

	always #10 clk = ~clk;

	// Current word as inverted magnitude with sign clear
	assign i_word = {1'b0, ~11'(plant_mag)};

	//////////////////////////////
	// Plant and reference state
	//////////////////////////////
	always @(posedge clk) begin
		if (reset) begin
			cs_age      <= 0;
			strobe_gap  <= 0;
			btn_age     <= 0;
			fire_age    <= 0;
			blink_age   <= 0;
			hi_len      <= 0;
			lo_len      <= 0;
			plant_mag   <= 0;
			exp_charge  <= 1'b1;
			firing_q    <= 1'b0;
			fire_starts <= 0;
		end else begin
			cs_age     <= o_ad_cs ? 1 : cs_age + 1;
			strobe_gap <= o_ad_strobe ? 1 : strobe_gap + 1;
			strobes    <= strobes + (o_ad_strobe ? 1 : 0);
			btn_age    <= fire_button ? btn_age + 1 : 0;
			fire_age   <= o_firing ? fire_age + 1 : fire_age;
			blink_age  <= (blink_age == BLINK_CYC - 1) ? 0 : blink_age + 1;
			hi_len     <= o_pwm ? hi_len + 1 : 0;
			lo_len     <= (!o_pwm && o_firing) ? lo_len + 1 : 0;
			pulses     <= pulses + ((o_pwm && hi_len == 0) ? 1 : 0);
			if (lt3420_done) exp_charge <= 1'b0;  // Off after done
			firing_q <= o_firing;
			if (o_firing && !firing_q) fire_starts <= fire_starts + 1;
			// Coil charges 2 DN per cycle while on, drains when off
			if (o_pwm) plant_mag <= (plant_mag > 2045) ? 2047 : plant_mag + 2;
			else       plant_mag <= (plant_mag < 2) ? 0 : plant_mag - 2;
			// Low window alone never lifts the coil this high
			if (o_firing && fire_age > 400 && plant_mag > launcher_pkg::I_LO_BOOST)
				boost_reached <= 1'b1;
		end
	end

	//////////////////////////////
	// Assertions
	//////////////////////////////
	assert property (@(posedge clk) disable iff (reset)
		o_ad_strobe |-> cs_age == 15 && (strobes == 0 || strobe_gap == 16))
		else begin
			errors++;
			$display("Mismatch strobe timing: cs_age %h gap %h", cs_age, strobe_gap);
		end
	assert property (@(posedge clk) disable iff (reset)
		o_ad_strobe |-> o_v_cap.raw == 12'(frame_v + launcher_pkg::ADC_BIAS_V))
		else begin
			errors++;
			$display("Mismatch o_v_cap: got %h expected %h", o_v_cap.raw,
				12'(frame_v + launcher_pkg::ADC_BIAS_V));
		end
	assert property (@(posedge clk) disable iff (reset)
		o_ad_strobe |-> o_i_out.raw == 12'(frame_i + launcher_pkg::ADC_BIAS_I))
		else begin
			errors++;
			$display("Mismatch o_i_out: got %h expected %h", o_i_out.raw,
				12'(frame_i + launcher_pkg::ADC_BIAS_I));
		end
	assert property (@(posedge clk) disable iff (reset) o_lt3420_charge == exp_charge)
		else begin
			errors++;
			$display("Mismatch o_lt3420_charge: got %h expected %h", o_lt3420_charge, exp_charge);
		end
	// Armed flag can never set, so the LED is the blink phase while charging
	assert property (@(posedge clk) disable iff (reset)
		o_arm_led == (exp_charge && blink_age < BLINK_ON))
		else begin
			errors++;
			$display("Mismatch o_arm_led: got %h expected %h", o_arm_led,
				exp_charge && blink_age < BLINK_ON);
		end
	assert property (@(posedge clk) disable iff (reset) (o_firing || o_dump) |-> long_press)
		else begin
			errors++;
			$display("Burn started without a debounced press");
		end
	assert property (@(posedge clk) disable iff (reset)
		$rose(o_firing) |-> btn_age >= 80 && btn_age <= 100 && fire_starts == 0)
		else begin
			errors++;
			$display("Mismatch firing start: press age %h starts %h", btn_age, fire_starts);
		end
	assert property (@(posedge clk) disable iff (reset)
		$rose(o_dump) |-> $fell(o_firing) && fire_age == BURN_CYC - 1)  // Firing starts one count in
		else begin
			errors++;
			$display("Mismatch burn end: firing %h length %h expected %h", o_firing, fire_age,
				BURN_CYC - 1);
		end
	assert property (@(posedge clk) disable iff (reset) $past(o_dump) |-> o_dump)
		else begin
			errors++;
			$display("Dump released before reset");
		end
	assert property (@(posedge clk) disable iff (reset)
		$fell(o_pwm) |-> hi_len >= 32 && hi_len <= 768)
		else begin
			errors++;
			$display("Mismatch pwm high length: got %h", hi_len);
		end
	assert property (@(posedge clk) disable iff (reset)
		$rose(o_pwm) |-> $past(o_firing) && lo_len >= 192)
		else begin
			errors++;
			$display("Mismatch pwm start: low gap %h", lo_len);
		end
	assert property (@(posedge clk) disable iff (reset)
		o_firing |-> plant_mag < ((fire_age >= 170) ? 840 : 430) + MARGIN)
		else begin
			errors++;
			$display("Mismatch plant current: got %h", plant_mag);
		end

	task automatic step(input int n);
		repeat (n) @(posedge clk);
		#2;
	endtask

	//////////////////////////////
	// Stimulus
	//////////////////////////////
	initial begin
		void'($urandom(99939));
		clk = 1'b0;
		reset = 1'b1;
		fire_button = 1'b0;
		lt3420_done = 1'b0;
		v_word = {1'b0, ~11'd100};
		errors = 0;
		strobes = 0;
		pulses = 0;
		long_press = 1'b0;
		boost_reached = 1'b0;
		step(4);
		reset = 1'b0;
		repeat (1000) begin  // Random cap voltage while charging
			step(1);
			v_word = 12'($urandom);
		end
		lt3420_done = 1'b1;
		step(1);
		lt3420_done = 1'b0;
		v_word = 12'h000;  // Full scale above 300 V
		step(200);
		v_word = {1'b0, ~11'd100};  // Below 50 V
		step(200);
		fire_button = 1'b1;  // Too short
		step(40);
		fire_button = 1'b0;
		step(300);
		long_press = 1'b1;
		fire_button = 1'b1;
		step(600);
		fire_button = 1'b0;
		while (!o_dump) step(1);
		step(2000);  // Past release time
		fire_button = 1'b1;  // No second burn
		step(600);
		fire_button = 1'b0;
		step(100);
		assert (boost_reached) else begin
			errors++;
			$display("Current never rose above the low window after boost");
		end
		$display("Errors %0d, strobes %0d, pwm pulses %0d", errors, strobes, pulses);
		if (errors == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

	// Watchdog
	initial begin
		#(TIMEOUT_CYCLES * 20);
		$display("Timeout, burn sequence did not complete");
		$display("CHECKS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* dv/adc_serial_model.sv */
`default_nettype none

// Serial ADC model, answers chip select with two words MSB first
module adc_serial_model (
	input  wire logic        clk,
	input  wire logic        reset,
	input  wire logic        i_cs,
	input  wire logic [11:0] i_word_i,   // Current channel word
	input  wire logic [11:0] i_word_v,   // Cap voltage channel word
	output logic [1:0]       o_sdata,    // [0] current, [1] voltage
	output logic [11:0]      o_frame_i,  // Word sent in this frame
	output logic [11:0]      o_frame_v
);

	int cnt;  // Cycle within frame, 0 when idle

	initial begin
		cnt       = 0;
		o_sdata   = 2'b00;
		o_frame_i = '0;
		o_frame_v = '0;
	end

	//////////////////////////////
	// Frame walk
	//////////////////////////////
	always @(posedge clk) begin
		if (reset) begin
			cnt = 0;
		end else if (i_cs) begin
			cnt       = 1;          // cs seen at end of cycle 0
			o_frame_i = i_word_i;   // Latch both words
			o_frame_v = i_word_v;
		end else if (cnt != 0 && cnt < 15) begin
			cnt = cnt + 1;
		end else begin
			cnt = 0;
		end
		#2;
		// Bit 11 in cycle 2 down to bit 0 in cycle 13
		if (cnt >= 2 && cnt <= 13) begin
			o_sdata = {o_frame_v[13-cnt], o_frame_i[13-cnt]};
		end else begin
			o_sdata = 2'b00;
		end
	end

endmodule

`default_nettype wire

/* logic/launcher_top.sv */
`default_nettype none

// Model rocket launcher firing path
module launcher_top #(
	parameter int CYCLES_PER_MS = 48000
) (
	input  wire logic               clk,
	input  wire logic               reset,
	input  wire logic               i_fire_button,
	input  wire logic               i_lt3420_done,
	input  wire logic [1:0]         i_ad_sdata_a,
	output logic                    o_ad_cs,
	output logic                    o_ad_strobe,
	output launcher_pkg::adc_word_t o_i_out,
	output launcher_pkg::adc_word_t o_v_cap,
	output logic                    o_firing,
	output logic                    o_pwm,
	output logic                    o_dump,
	output logic                    o_lt3420_charge,
	output logic                    o_arm_led
);

	logic fire_pulse;  // Debounced press
	logic boost;       // 4 A setpoint

	//////////////////////////////
	// Sensing and control
	//////////////////////////////
	adc_receiver i_adc_receiver (
		.clk          (clk),
		.reset        (reset),
		.i_ad_sdata_a (i_ad_sdata_a),
		.o_ad_cs      (o_ad_cs),
		.o_ad_strobe  (o_ad_strobe),
		.o_i_out      (o_i_out),
		.o_v_cap      (o_v_cap)
	);

	fire_debounce #(.CYCLES_PER_MS(CYCLES_PER_MS)) i_fire_debounce (
		.clk           (clk),
		.reset         (reset),
		.i_fire_button (i_fire_button),
		.o_fire_pulse  (fire_pulse)
	);

	fire_sequencer #(.CYCLES_PER_MS(CYCLES_PER_MS)) i_fire_sequencer (
		.clk          (clk),
		.reset        (reset),
		.i_fire_pulse (fire_pulse),
		.o_firing     (o_firing),
		.o_boost      (boost),
		.o_dump       (o_dump)
	);

	pwm_current_regulator i_pwm_current_regulator (
		.clk      (clk),
		.reset    (reset),
		.i_firing (o_firing),
		.i_boost  (boost),
		.i_i_out  (o_i_out),
		.o_pwm    (o_pwm)
	);

	charge_arm_control #(.CYCLES_PER_MS(CYCLES_PER_MS)) i_charge_arm_control (
		.clk             (clk),
		.reset           (reset),
		.i_lt3420_done   (i_lt3420_done),
		.i_ad_strobe     (o_ad_strobe),
		.i_v_cap         (o_v_cap),
		.o_lt3420_charge (o_lt3420_charge),
		.o_arm_led       (o_arm_led)
	);

endmodule

`default_nettype wire

/* logic/charge_arm_control.sv */
`default_nettype none

// Power-on charger enable and arm LED
module charge_arm_control #(
	parameter int CYCLES_PER_MS = 48000
) (
	input  wire logic                    clk,
	input  wire logic                    reset,
	input  wire logic                    i_lt3420_done,
	input  wire logic                    i_ad_strobe,
	input  wire launcher_pkg::adc_word_t i_v_cap,
	output logic                         o_lt3420_charge,
	output logic                         o_arm_led
);

	localparam int MAG_W        = launcher_pkg::ADC_BITS - 1;
	localparam int SENSE_W      = launcher_pkg::ARM_SENSE_BITS;
	localparam int BLINK_CYC    = launcher_pkg::BLINK_PERIOD_MS * CYCLES_PER_MS;
	localparam int BLINK_W      = $clog2(BLINK_CYC);
	localparam logic [BLINK_W-1:0] BLINK_LAST = BLINK_W'(BLINK_CYC - 1);
	localparam logic [BLINK_W-1:0] BLINK_ON   = BLINK_W'(launcher_pkg::BLINK_ON_MS * CYCLES_PER_MS);

	logic [MAG_W-1:0]   v_mag;      // Cap voltage, DN
	logic [SENSE_W-1:0] v_level;    // Saturated sense level
	logic               armed;
	logic [BLINK_W-1:0] blink_cnt;  // Phase in blink period
	logic               blink;

	assign v_mag   = launcher_pkg::adc_mag(i_v_cap);
	assign v_level = (|v_mag[MAG_W-1:SENSE_W]) ? '1 : v_mag[SENSE_W-1:0];  // Tops out at 1023 DN
	assign blink   = (blink_cnt < BLINK_ON);

	always_ff @(posedge clk) begin
		if (reset) begin
			o_lt3420_charge <= 1'b1;                // Charge from power on
			armed           <= 1'b0;
			blink_cnt       <= '0;
		end else begin
			if (o_lt3420_charge && i_lt3420_done) begin
				o_lt3420_charge <= 1'b0;            // Charger done, stays off
			end

			// 300 V on, 50 V off hysteresis, sampled on strobe
			if (i_ad_strobe) begin
				if (MAG_W'(v_level) > launcher_pkg::V_ARM_ON) begin
					armed <= 1'b1;
				end else if (MAG_W'(v_level) < launcher_pkg::V_ARM_OFF) begin
					armed <= 1'b0;
				end
			end

			blink_cnt <= (blink_cnt == BLINK_LAST) ? '0 : blink_cnt + 1'b1;
		end
	end

	assign o_arm_led = armed | (o_lt3420_charge & blink);  // Blink while charging

endmodule

`default_nettype wire

/* logic/pwm_current_regulator.sv */
`default_nettype none

// Hysteretic current limited PWM for the buck output
module pwm_current_regulator (
	input  wire logic                    clk,
	input  wire logic                    reset,
	input  wire logic                    i_firing,
	input  wire logic                    i_boost,
	input  wire launcher_pkg::adc_word_t i_i_out,
	output logic                         o_pwm
);

	localparam int PT_W = launcher_pkg::PULSE_CNT_BITS;

	logic [launcher_pkg::ADC_BITS-2:0] i_mag;       // Output current, DN
	logic [launcher_pkg::ADC_BITS-2:0] thresh_hi;   // Pulse end level
	logic [launcher_pkg::ADC_BITS-2:0] thresh_lo;   // Pulse start level
	logic [PT_W-1:0]                   pulse_time;  // On or off time so far

	// Negative readings count as zero current
	assign i_mag = launcher_pkg::adc_mag(i_i_out);

	//////////////////////////////
	// Setpoint window
	//////////////////////////////
	always_ff @(posedge clk) begin
		thresh_hi <= i_boost ? launcher_pkg::I_HI_BOOST : launcher_pkg::I_HI_LOW_SET;
		thresh_lo <= i_boost ? launcher_pkg::I_LO_BOOST : launcher_pkg::I_LO_LOW_SET;
	end

	//////////////////////////////
	// Pulse generator
	//////////////////////////////
	always_ff @(posedge clk) begin
		if (reset) begin
			o_pwm      <= 1'b0;
			pulse_time <= '0;
		end else if (o_pwm) begin
			// Running pulse always completes, even after firing ends
			if (pulse_time < launcher_pkg::PULSE_MIN_ON) begin
				pulse_time <= pulse_time + 1'b1;    // Minimum on time
			end else if (pulse_time >= launcher_pkg::PULSE_MAX_ON ||
			             i_mag > thresh_hi) begin
				o_pwm      <= 1'b0;                 // Time or current limit
				pulse_time <= '0;
			end else begin
				pulse_time <= pulse_time + 1'b1;
			end
		end else if (i_firing) begin
			if (pulse_time < launcher_pkg::PULSE_MIN_OFF) begin
				pulse_time <= pulse_time + 1'b1;    // Minimum off time
			end else if (i_mag < thresh_lo) begin
				o_pwm      <= 1'b1;                 // Current fell below window
				pulse_time <= PT_W'(1);
			end
			// Otherwise hold at min off until current drops
		end else begin
			pulse_time <= '0;                       // Idle, no new pulses
		end
	end

endmodule

`default_nettype wire

/* logic/fire_sequencer.sv */
`default_nettype none

// Burn timer, one burn per reset
module fire_sequencer #(
	parameter int CYCLES_PER_MS = 48000
) (
	input  wire logic clk,
	input  wire logic reset,
	input  wire logic i_fire_pulse,
	output logic      o_firing,
	output logic      o_boost,
	output logic      o_dump
);

	localparam int CNT_W = launcher_pkg::FIRE_CNT_BITS;
	localparam logic [CNT_W-1:0] START_CNT = CNT_W'(1);
	localparam logic [CNT_W-1:0] BOOST_CNT = CNT_W'(launcher_pkg::BOOST_START_MS * CYCLES_PER_MS);
	localparam logic [CNT_W-1:0] END_CNT   = CNT_W'(launcher_pkg::BURN_END_MS * CYCLES_PER_MS);

	logic [CNT_W-1:0] fire_cnt;  // Cycles since commit
	logic             at_end;

	assign at_end = (fire_cnt == END_CNT);

	//////////////////////////////
	// Burn timing
	//////////////////////////////
	always_ff @(posedge clk) begin
		if (reset) begin
			fire_cnt <= '0;
			o_firing <= 1'b0;
			o_boost  <= 1'b0;
			o_dump   <= 1'b0;
		end else begin
			// Committed on first pulse, stops at end of burn
			if ((fire_cnt != '0 || i_fire_pulse) && !at_end) begin
				fire_cnt <= fire_cnt + 1'b1;
			end

			if (fire_cnt == START_CNT) begin
				o_firing <= 1'b1;           // Two cycles after pulse
			end else if (at_end) begin
				o_firing <= 1'b0;
			end

			// 2 A to 4 A setpoint step
			if (fire_cnt == BOOST_CNT) begin
				o_boost <= 1'b1;
			end else if (at_end) begin
				o_boost <= 1'b0;
			end

			if (at_end) begin
				o_dump <= 1'b1;             // Latched until reset
			end
		end
	end

endmodule

`default_nettype wire

/* logic/fire_debounce.sv */
`default_nettype none

// Fire button debouncer, one fixed pulse per press
module fire_debounce #(
	parameter int CYCLES_PER_MS = 48000
) (
	input  wire logic clk,
	input  wire logic reset,
	input  wire logic i_fire_button,
	output logic      o_fire_pulse
);

	localparam int PRESS_CYC   = launcher_pkg::DEBOUNCE_PRESS_MS * CYCLES_PER_MS;
	localparam int PULSE_CYC   = launcher_pkg::DEBOUNCE_PULSE_END_MS * CYCLES_PER_MS;
	localparam int RELEASE_CYC = launcher_pkg::DEBOUNCE_RELEASE_MS * CYCLES_PER_MS;
	localparam int PRESS_W     = $clog2(PULSE_CYC + 1);
	localparam int RELEASE_W   = $clog2(RELEASE_CYC + 1);

	logic [launcher_pkg::SYNC_STAGES-1:0]   sync;         // Button synchronizer
	logic                                   button_s;
	logic [launcher_pkg::DB_STATE_BITS-1:0] state;
	logic [PRESS_W-1:0]                     press_cnt;    // Time since press start
	logic [RELEASE_W-1:0]                   release_cnt;  // Time low while waiting

	assign button_s = sync[launcher_pkg::SYNC_STAGES-1];

	always_ff @(posedge clk) begin
		if (reset) begin
			sync <= '0;
		end else begin
			sync <= {sync[launcher_pkg::SYNC_STAGES-2:0], i_fire_button};
		end
	end

	//////////////////////////////
	// Press state machine
	//////////////////////////////
	always_ff @(posedge clk) begin
		if (reset) begin
			state <= launcher_pkg::DB_IDLE;
		end else begin
			case (state)
				launcher_pkg::DB_IDLE:
					if (button_s) state <= launcher_pkg::DB_WAIT_PRESS;
				launcher_pkg::DB_WAIT_PRESS:
					if (!button_s)                              state <= launcher_pkg::DB_IDLE;  // Too short
					else if (press_cnt == PRESS_W'(PRESS_CYC))  state <= launcher_pkg::DB_PULSE;
				launcher_pkg::DB_PULSE:
					if (press_cnt == PRESS_W'(PULSE_CYC))       state <= launcher_pkg::DB_HELD;
				launcher_pkg::DB_HELD:
					if (!button_s)                              state <= launcher_pkg::DB_WAIT_RELEASE;
				launcher_pkg::DB_WAIT_RELEASE:
					if (button_s)                               state <= launcher_pkg::DB_HELD;  // Bounce
					else if (release_cnt == RELEASE_W'(RELEASE_CYC)) state <= launcher_pkg::DB_IDLE;
				default:
					state <= launcher_pkg::DB_IDLE;
			endcase
		end
	end

	// Counters
	always_ff @(posedge clk) begin
		if (reset) begin
			press_cnt   <= '0;
			release_cnt <= '0;
		end else begin
			press_cnt   <= (state == launcher_pkg::DB_WAIT_PRESS ||
			                state == launcher_pkg::DB_PULSE) ? press_cnt + 1'b1 : '0;
			release_cnt <= (state == launcher_pkg::DB_WAIT_RELEASE) ? release_cnt + 1'b1 : '0;
		end
	end

	assign o_fire_pulse = (state == launcher_pkg::DB_PULSE);  // 20 ms pulse

endmodule

`default_nettype wire

/* logic/adc_receiver.sv */
`default_nettype none

// Two channel serial ADC receiver, one conversion per 16 clocks
module adc_receiver (
	input  wire logic                   clk,
	input  wire logic                   reset,
	input  wire logic [1:0]             i_ad_sdata_a,  // [0] current, [1] cap voltage
	output logic                        o_ad_cs,
	output logic                        o_ad_strobe,
	output launcher_pkg::adc_word_t     o_i_out,
	output launcher_pkg::adc_word_t     o_v_cap
);

	logic [launcher_pkg::ADC_DIV_BITS-1:0]  frame_cnt;  // Frame divider
	logic [launcher_pkg::ADC_STROBE_TAP:0]  cs_dly;     // cs_dly[k] high in cycle k+1
	logic [launcher_pkg::ADC_BITS-1:0]      load;       // One-hot bit position
	logic [launcher_pkg::ADC_BITS-1:0]      load_i;     // Current word being shifted in
	logic [launcher_pkg::ADC_BITS-1:0]      load_v;     // Voltage word being shifted in

	//////////////////////////////
	// Frame timing
	//////////////////////////////
	always_ff @(posedge clk) begin
		if (reset) begin
			frame_cnt <= '0;
			o_ad_cs   <= 1'b0;
			cs_dly    <= '0;
			load      <= '0;
		end else begin
			frame_cnt <= (frame_cnt == launcher_pkg::ADC_FRAME_LAST) ? '0 : frame_cnt + 1'b1;
			o_ad_cs   <= (frame_cnt == launcher_pkg::ADC_FRAME_LAST);  // Cycle 0 of frame
			// Chip select shift chain drives the rest of the frame
			cs_dly    <= {cs_dly[launcher_pkg::ADC_STROBE_TAP-1:0], o_ad_cs};
			// MSB position in cycle 2, LSB in cycle 13
			load      <= {cs_dly[0], load[launcher_pkg::ADC_BITS-1:1]};
		end
	end

	// Serial capture, MSB first
	always_ff @(posedge clk) begin
		for (int ii = 0; ii < launcher_pkg::ADC_BITS; ii++) begin
			if (load[ii]) begin
				load_i[ii] <= i_ad_sdata_a[0];
				load_v[ii] <= i_ad_sdata_a[1];
			end
		end
	end

	//////////////////////////////
	// Hold registers
	//////////////////////////////
	always_ff @(posedge clk) begin
		if (reset) begin
			o_i_out <= '0;
			o_v_cap <= '0;
		end else if (cs_dly[launcher_pkg::ADC_HOLD_TAP]) begin  // End of cycle 14
			o_i_out.raw <= load_i + launcher_pkg::ADC_BIAS_I;
			o_v_cap.raw <= load_v + launcher_pkg::ADC_BIAS_V;
		end
	end

	// New words valid in cycle 15
	assign o_ad_strobe = cs_dly[launcher_pkg::ADC_STROBE_TAP];

endmodule

`default_nettype wire

/* logic/launcher_pkg.sv */
`default_nettype none

package launcher_pkg;

	//////////////////////////////
	// ADC word format
	//////////////////////////////
	localparam int ADC_BITS = 12;

	// Biased word from the ADC, offset binary with inverted magnitude
	typedef union packed {
		logic [ADC_BITS-1:0] raw;        // Word as held
		struct packed {
			logic                neg;    // Set when below zero
			logic [ADC_BITS-2:0] mag_n;  // Inverted magnitude
		} field;
	} adc_word_t;

	// Magnitude, negative values clip to zero
	function automatic logic [ADC_BITS-2:0] adc_mag(input adc_word_t w);
		return w.field.neg ? '0 : ~w.field.mag_n;
	endfunction

	//////////////////////////////
	// ADC frame, 3 MHz at 48 MHz clock
	//////////////////////////////
	localparam int ADC_FRAME_CYCLES = 16;
	localparam int ADC_DIV_BITS     = $clog2(ADC_FRAME_CYCLES);
	localparam logic [ADC_DIV_BITS-1:0] ADC_FRAME_LAST = ADC_DIV_BITS'(ADC_FRAME_CYCLES - 1);
	localparam int ADC_HOLD_TAP     = 13;  // cs delay tap high in cycle 14
	localparam int ADC_STROBE_TAP   = 14;  // cs delay tap high in cycle 15
	localparam logic [ADC_BITS-1:0] ADC_BIAS_I = 12'd5;   // Current channel offset
	localparam logic [ADC_BITS-1:0] ADC_BIAS_V = 12'd5;   // Cap voltage channel offset

	//////////////////////////////
	// Current regulator
	//////////////////////////////
	localparam int PULSE_CNT_BITS = 10;
	localparam logic [PULSE_CNT_BITS-1:0] PULSE_MIN_ON  = 10'd32;   // 0.67 us
	localparam logic [PULSE_CNT_BITS-1:0] PULSE_MAX_ON  = 10'd768;  // 16 us
	localparam logic [PULSE_CNT_BITS-1:0] PULSE_MIN_OFF = 10'd192;  // 4 us

	// 205 DN per amp, +/- 20 DN window
	localparam logic [ADC_BITS-2:0] I_HI_LOW_SET = 11'd430;  // 2 A window
	localparam logic [ADC_BITS-2:0] I_LO_LOW_SET = 11'd390;
	localparam logic [ADC_BITS-2:0] I_HI_BOOST   = 11'd840;  // 4 A window
	localparam logic [ADC_BITS-2:0] I_LO_BOOST   = 11'd800;

	//////////////////////////////
	// Arm sense, 0.2005 V per DN
	//////////////////////////////
	localparam int ARM_SENSE_BITS = 10;  // Saturating sense level width
	localparam logic [ADC_BITS-2:0] V_ARM_ON  = 11'd1496;  // 300 V
	localparam logic [ADC_BITS-2:0] V_ARM_OFF = 11'd249;   // 50 V

	// Millisecond timings, scaled by cycles per ms at the top
	localparam int DEBOUNCE_PRESS_MS     = 5;
	localparam int DEBOUNCE_PULSE_END_MS = 25;
	localparam int DEBOUNCE_RELEASE_MS   = 100;
	localparam int BOOST_START_MS        = 11;
	localparam int BURN_END_MS           = 1333;
	localparam int BLINK_PERIOD_MS       = 700;
	localparam int BLINK_ON_MS           = 44;

	localparam int SYNC_STAGES   = 3;   // Button synchronizer depth
	localparam int FIRE_CNT_BITS = 28;  // Burn timer width

	// Debouncer states
	localparam int DB_STATE_BITS = 3;
	localparam logic [DB_STATE_BITS-1:0] DB_IDLE         = 3'd0;
	localparam logic [DB_STATE_BITS-1:0] DB_WAIT_PRESS   = 3'd1;
	localparam logic [DB_STATE_BITS-1:0] DB_PULSE        = 3'd2;
	localparam logic [DB_STATE_BITS-1:0] DB_HELD         = 3'd3;
	localparam logic [DB_STATE_BITS-1:0] DB_WAIT_RELEASE = 3'd4;

endpackage

`default_nettype wire
